/* src/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // U-type view, used for LUI
    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_u_fmt_t;

    // R/system view, used for the custom words and MRET
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_sys_fmt_t;

    typedef union packed {
        rv_u_fmt_t   u_view;
        rv_sys_fmt_t sys_view;
    } rv_instr_u;

    localparam logic [6:0]  OPC_LUI         = 7'b0110111;
    localparam logic [31:0] INSTR_MRET      = 32'h0000_0000;
    localparam logic [31:0] INSTR_LOAD_KEY  = 32'hffff_ffff;       // Custom load, key -> x5
    localparam logic [31:0] INSTR_STORE_ART = 32'hffff_ff7f;       // Same word with rd = 30
    localparam logic [31:0] INSTR_RESET     = 32'h0000_0001;       // Decodes as nothing
    localparam logic [31:0] INSTR_NOP       = 32'h0000_0013;       // addi x0,x0,0 filler

    localparam logic [63:0] RAM_BASE    = 64'h0000_0000_0000_1000; // Reset PC, main program
    localparam logic [63:0] KEY_BASE    = 64'h0000_0000_1000_0000;
    localparam logic [63:0] ART_BASE    = 64'h0000_0000_1000_0008;
    localparam logic [63:0] TRAP_VECTOR = 64'h0000_0000_0000_0000; // Handler region

    localparam int ROM_WORDS = 16;

    // LUI x5 words are {imm20, 5'd5, OPC_LUI}, low 12 bits 0x2b7
    localparam logic [31:0] MAIN_PROG [0:ROM_WORDS-1] = '{
        32'h1234_52b7, INSTR_STORE_ART, INSTR_LOAD_KEY, INSTR_STORE_ART,
        INSTR_NOP,     32'habcd_e2b7,   INSTR_STORE_ART, INSTR_NOP,
        INSTR_LOAD_KEY, INSTR_STORE_ART, 32'h00f0_f2b7, INSTR_STORE_ART,
        INSTR_NOP,     INSTR_LOAD_KEY,  INSTR_STORE_ART, INSTR_NOP
    };

    // Marker, store it, return
    localparam logic [31:0] TRAP_PROG [0:ROM_WORDS-1] = '{
        32'h7eee_e2b7, INSTR_STORE_ART, INSTR_MRET, INSTR_MRET,
        INSTR_MRET,    INSTR_MRET,      INSTR_MRET, INSTR_MRET,
        INSTR_MRET,    INSTR_MRET,      INSTR_MRET, INSTR_MRET,
        INSTR_MRET,    INSTR_MRET,      INSTR_MRET, INSTR_MRET
    };

endpackage

`default_nettype wire

/* src/inst_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_rom (
    input  wire [63:0] pc,
    output logic [31:0] instruction
);

    logic       in_trap_region; // PC below main program base
    logic [3:0] word_idx;

    assign in_trap_region = (pc < rv_pkg::RAM_BASE);
    assign word_idx       = pc[5:2]; // Both regions wrap every 16 words

    // Pure lookup, no clock
    always_comb begin
        if (in_trap_region) begin
            instruction = rv_pkg::TRAP_PROG[word_idx];
        end else begin
            instruction = rv_pkg::MAIN_PROG[word_idx];
        end
    end

endmodule

`default_nettype wire

/* src/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  wire rv_pkg::rv_instr_u ir,
    output logic                   is_lui,
    output logic                   is_mret,
    output logic                   is_load,
    output logic                   is_store,
    output logic [4:0]             rd,
    output logic [63:0]            imm_u
);

    rv_pkg::rv_instr_u pat_mret;
    rv_pkg::rv_instr_u pat_load;
    rv_pkg::rv_instr_u pat_store;

    // Compare every R-type field of two words
    function automatic logic sys_match(
        input rv_pkg::rv_instr_u word,
        input rv_pkg::rv_instr_u pat
    );
        logic hi_ok;
        logic lo_ok;
        hi_ok = (word.sys_view.funct7 == pat.sys_view.funct7)
              && (word.sys_view.rs2 == pat.sys_view.rs2)
              && (word.sys_view.rs1 == pat.sys_view.rs1);
        lo_ok = (word.sys_view.funct3 == pat.sys_view.funct3)
              && (word.sys_view.rd == pat.sys_view.rd)
              && (word.sys_view.opcode == pat.sys_view.opcode);
        return hi_ok && lo_ok;
    endfunction

    assign pat_mret  = rv_pkg::INSTR_MRET;
    assign pat_load  = rv_pkg::INSTR_LOAD_KEY;
    assign pat_store = rv_pkg::INSTR_STORE_ART;

    // Only the opcode matters for LUI
    assign is_lui   = (ir.u_view.opcode == rv_pkg::OPC_LUI);
    assign is_mret  = sys_match(ir, pat_mret);   // All zero word
    assign is_load  = sys_match(ir, pat_load);
    assign is_store = sys_match(ir, pat_store);  // Differs from load in rd only

    assign rd = ir.u_view.rd;

    // Sign extend from bit 31, low 12 bits zero
    assign imm_u = {{32{ir.u_view.imm20[19]}}, ir.u_view.imm20, 12'b0};

endmodule

`default_nettype wire

/* src/rv_trap.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_trap #(
    parameter int XLEN = 64
) (
    input  wire            clk,
    input  wire            reset,
    input  wire [3:0]      interrupt_vector,
    input  wire [XLEN-1:0] pc,
    input  wire            mret_commit,        // Handler return retired
    output logic           take_trap,
    output logic [XLEN-1:0] mepc,
    output logic           interrupt_pending,
    output logic           interrupt_ack
);

    logic vector_hit;

    // Only external cause 1 is serviced
    assign vector_hit = (interrupt_vector == 4'd1);

    // Masked while a trap is in service, so a held request fires once
    assign take_trap = vector_hit && !interrupt_pending;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            interrupt_pending <= 1'b0;
            interrupt_ack     <= 1'b0;
        end else begin
            interrupt_ack <= take_trap; // One cycle, pending blocks a repeat
            if (take_trap) begin
                interrupt_pending <= 1'b1;
            end else if (mret_commit) begin
                interrupt_pending <= 1'b0;
            end
        end
    end

    // Return address is the next fetch address at the trap edge
    always_ff @(posedge clk) begin
        if (take_trap) begin
            mepc <= pc;
        end
    end

endmodule

`default_nettype wire

/* src/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_execute #(
    parameter int XLEN     = 64,
    parameter int NUM_REGS = 32
) (
    input  wire                clk,
    input  wire                reset,
    input  wire [31:0]         instruction,     // From ROM at pc
    input  wire                is_lui,
    input  wire                is_mret,
    input  wire                is_load,
    input  wire                is_store,
    input  wire [4:0]          rd,
    input  wire [XLEN-1:0]     imm_u,
    input  wire                take_trap,
    input  wire [XLEN-1:0]     mepc,
    output rv_pkg::rv_instr_u  ir,
    output logic [XLEN-1:0]    pc,
    output logic               mret_commit,
    output logic               heartbeat,
    output logic [XLEN-1:0]    bus_address,
    output logic [XLEN-1:0]    bus_write_data,
    output logic               bus_write_enable,
    output logic               bus_read_enable,
    input  wire [XLEN-1:0]     bus_read_data
);

    logic [XLEN-1:0] regs [NUM_REGS];   // x5 is the only one read back

    logic            bubble;            // Slot in ir is discarded
    logic            lb_step;           // Load waits for its re-fetch
    logic            exec_slot;
    logic            load_issue;
    logic            load_finish;
    logic            store_fire;
    logic            reg_we;
    logic [4:0]      reg_waddr;
    logic [XLEN-1:0] reg_wdata;

    assign exec_slot   = !bubble;
    assign load_issue  = exec_slot && is_load && !lb_step && !take_trap; // Dropped on a trap
    assign load_finish = exec_slot && is_load && lb_step;
    assign store_fire  = exec_slot && is_store;
    assign mret_commit = exec_slot && is_mret && !take_trap;

    // LUI and the load result share one write port, x0 stays zero
    assign reg_we    = (exec_slot && is_lui && (rd != 5'd0)) || load_finish;
    assign reg_waddr = load_finish ? 5'd5 : rd;
    assign reg_wdata = load_finish ? bus_read_data : imm_u;

    // Fetch register and heartbeat
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir        <= rv_pkg::INSTR_RESET;
            heartbeat <= 1'b0;
        end else begin
            ir        <= instruction;
            heartbeat <= ~heartbeat;
        end
    end

    always_ff @(posedge clk) begin
        if (reg_we) begin
            regs[reg_waddr] <= reg_wdata;
        end
    end

    // PC and slot control, trap > bubble > decoded op
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc               <= rv_pkg::RAM_BASE;
            bubble           <= 1'b0;
            lb_step          <= 1'b0;
            bus_read_enable  <= 1'b0;
            bus_write_enable <= 1'b0;
        end else begin
            pc               <= pc + 4;      // Default sequential fetch
            bus_write_enable <= store_fire;  // A live store still retires beside a trap
            if (take_trap) begin
                pc              <= rv_pkg::TRAP_VECTOR;
                bubble          <= 1'b1;     // Kill the word fetched this edge
                lb_step         <= 1'b0;     // Interrupted load restarts from its issue
                bus_read_enable <= 1'b0;
            end else if (bubble) begin
                bubble <= 1'b0;              // Read strobe held across the load bubble
            end else if (mret_commit) begin
                pc     <= mepc;
                bubble <= 1'b1;
            end else if (load_issue) begin
                pc              <= pc - 4;   // Point back at the load so it is re-fetched
                bubble          <= 1'b1;
                lb_step         <= 1'b1;
                bus_read_enable <= 1'b1;
            end else if (load_finish) begin
                lb_step         <= 1'b0;
                bus_read_enable <= 1'b0;
            end
        end
    end

    // Bus payload, only meaningful with a strobe
    always_ff @(posedge clk) begin
        if (store_fire) begin
            bus_address    <= rv_pkg::ART_BASE;
            bus_write_data <= regs[5];
        end else if (load_issue) begin
            bus_address <= rv_pkg::KEY_BASE;
        end
    end

endmodule

`default_nettype wire

/* src/periph_bus.sv */
`timescale 1ns/1ps
`default_nettype none

module periph_bus #(
    parameter int XLEN = 64
) (
    input  wire             clk,
    input  wire             reset,
    input  wire [XLEN-1:0]  bus_address,
    input  wire [XLEN-1:0]  bus_write_data,
    input  wire             bus_write_enable,
    input  wire             bus_read_enable,
    output logic [XLEN-1:0] bus_read_data,
    input  wire [XLEN-1:0]  key_data,        // Key port, sampled on read
    output logic [XLEN-1:0] art_data,
    output logic            art_strobe       // One pulse per art write
);

    logic key_hit;
    logic art_hit;
    logic art_write;

    // Address decode
    assign key_hit   = (bus_address == rv_pkg::KEY_BASE);
    assign art_hit   = (bus_address == rv_pkg::ART_BASE);
    assign art_write = bus_write_enable && art_hit; // Other addresses fall on the floor

    // Read path is combinational, zero when idle
    assign bus_read_data = (bus_read_enable && key_hit) ? key_data : '0;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            art_strobe <= 1'b0;
        end else begin
            art_strobe <= art_write;
        end
    end

    // Art value lines up with its strobe
    always_ff @(posedge clk) begin
        if (art_write) begin
            art_data <= bus_write_data;
        end
    end

endmodule

`default_nettype wire

/* src/soc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_top #(
    parameter int XLEN     = 64,
    parameter int NUM_REGS = 32
) (
    input  wire             clk,
    input  wire             reset,
    input  wire [3:0]       interrupt_vector,
    input  wire [XLEN-1:0]  key_data,
    output logic [XLEN-1:0] art_data,
    output logic            art_strobe,
    output logic            interrupt_ack,
    output logic            interrupt_pending,
    output logic            heartbeat,
    output logic [XLEN-1:0] pc
);

    logic [31:0]       instruction;
    rv_pkg::rv_instr_u ir;

    // Decoder results
    logic              is_lui;
    logic              is_mret;
    logic              is_load;
    logic              is_store;
    logic [4:0]        rd;
    logic [63:0]       imm_u;

    // Trap unit handshake with execute
    logic              take_trap;
    logic              mret_commit;
    logic [XLEN-1:0]   mepc;

    // Peripheral bus
    logic [XLEN-1:0]   bus_address;
    logic [XLEN-1:0]   bus_write_data;
    logic              bus_write_enable;
    logic              bus_read_enable;
    logic [XLEN-1:0]   bus_read_data;

    inst_rom i_inst_rom (
        .pc          (pc),
        .instruction (instruction)
    );

    rv_decode i_rv_decode (
        .ir       (ir),
        .is_lui   (is_lui),
        .is_mret  (is_mret),
        .is_load  (is_load),
        .is_store (is_store),
        .rd       (rd),
        .imm_u    (imm_u)
    );

    rv_trap #(
        .XLEN (XLEN)
    ) i_rv_trap (
        .clk               (clk),
        .reset             (reset),
        .interrupt_vector  (interrupt_vector),
        .pc                (pc),
        .mret_commit       (mret_commit),
        .take_trap         (take_trap),
        .mepc              (mepc),
        .interrupt_pending (interrupt_pending),
        .interrupt_ack     (interrupt_ack)
    );

    rv_execute #(
        .XLEN     (XLEN),
        .NUM_REGS (NUM_REGS)
    ) i_rv_execute (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .is_lui           (is_lui),
        .is_mret          (is_mret),
        .is_load          (is_load),
        .is_store         (is_store),
        .rd               (rd),
        .imm_u            (imm_u),
        .take_trap        (take_trap),
        .mepc             (mepc),
        .ir               (ir),
        .pc               (pc),
        .mret_commit      (mret_commit),
        .heartbeat        (heartbeat),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data)
    );

    periph_bus #(
        .XLEN (XLEN)
    ) i_periph_bus (
        .clk              (clk),
        .reset            (reset),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data),
        .key_data         (key_data),
        .art_data         (art_data),
        .art_strobe       (art_strobe)
    );

endmodule

`default_nettype wire

/* verification/soc_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_assert (
    input wire clk,
    input wire reset,
    input wire interrupt_ack,
    input wire interrupt_pending,
    input wire bus_write_enable,
    input wire bus_read_enable
);

    // Acknowledge is a single cycle pulse
    property ack_single_pulse;
        @(posedge clk) disable iff (!reset) interrupt_ack |=> !interrupt_ack;
    endproperty

    // Read and write strobes never share a cycle
    property strobes_exclusive;
        @(posedge clk) disable iff (!reset) !(bus_write_enable && bus_read_enable);
    endproperty

    // A trap in service masks any new request, so no acknowledge follows
    property no_ack_while_pending;
        @(posedge clk) disable iff (!reset) interrupt_pending |=> !interrupt_ack;
    endproperty

    assert property (ack_single_pulse)
        else $error("interrupt_ack stayed high for more than one cycle");
    assert property (strobes_exclusive)
        else $error("bus read and write strobes high together");
    assert property (no_ack_while_pending)
        else $error("interrupt_ack raised while an interrupt is pending");

endmodule

// Trap unit and execute bus strobes meet in the top level
bind soc_top soc_assert i_soc_assert (
    .clk               (clk),
    .reset             (reset),
    .interrupt_ack     (interrupt_ack),
    .interrupt_pending (interrupt_pending),
    .bus_write_enable  (bus_write_enable),
    .bus_read_enable   (bus_read_enable)
);

`default_nettype wire

/* verification/soc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_tb;

    localparam int XLEN = 64;

    logic            clk = 1'b0;
    logic            reset;
    logic [3:0]      interrupt_vector;
    logic [XLEN-1:0] key_data;
    logic [XLEN-1:0] art_data;
    logic            art_strobe;
    logic            interrupt_ack;
    logic            interrupt_pending;
    logic            heartbeat;
    logic [XLEN-1:0] pc;

    int          errors    = 0;
    int          art_count = 0;
    int          ack_count = 0;
    logic        in_run    = 1'b0;     // Heartbeat check armed
    logic        prev_hb   = 1'b0;
    logic [31:0] rng_state = 32'hb495;
    logic [63:0] exp_art;
    logic [3:0]  last_store_idx = 4'd0; // Main word of the latest art store
    logic        last_in_trap   = 1'b0;

    // ISA level model of the ROM programs
    logic [3:0]  ref_idx     = 4'd0;
    logic [3:0]  ref_ret     = 4'd0;   // Main index saved while in the handler
    logic        ref_in_trap = 1'b0;
    logic        trap_armed  = 1'b0;
    logic [3:0]  trap_idx    = 4'd0;   // Main word the trap lands in front of
    logic [63:0] ref_x5      = '0;
    logic [63:0] ref_key     = '0;

    soc_top #(
        .XLEN     (XLEN),
        .NUM_REGS (32)
    ) i_soc_top (
        .clk               (clk),
        .reset             (reset),
        .interrupt_vector  (interrupt_vector),
        .key_data          (key_data),
        .art_data          (art_data),
        .art_strobe        (art_strobe),
        .interrupt_ack     (interrupt_ack),
        .interrupt_pending (interrupt_pending),
        .heartbeat         (heartbeat),
        .pc                (pc)
    );

    initial begin
        forever #20 clk = ~clk;        // 40 ns period
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Two LCG steps make one 64-bit key
    function automatic logic [63:0] new_key();
        logic [31:0] hi;
        rng_state = lcg_next(rng_state);
        hi        = rng_state;
        rng_state = lcg_next(rng_state);
        return {hi, rng_state};
    endfunction

    // Walks the programs up to the next art store, returns the stored x5
    function automatic logic [63:0] predict_art();
        logic [31:0] word;
        logic        found;
        int          steps;
        found = 1'b0;
        steps = 0;
        while (!found && steps < 64) begin
            if (!ref_in_trap && trap_armed && ref_idx == trap_idx) begin
                ref_in_trap = 1'b1;    // Handler runs in front of this word
                trap_armed  = 1'b0;
                ref_ret     = ref_idx;
                ref_idx     = 4'd0;
            end
            word    = ref_in_trap ? rv_pkg::TRAP_PROG[ref_idx] : rv_pkg::MAIN_PROG[ref_idx];
            ref_idx = ref_idx + 4'd1;  // Both regions wrap at 16 words
            steps++;
            if (word[6:0] == rv_pkg::OPC_LUI) begin
                ref_x5 = 64'($signed(word & 32'hffff_f000)); // Upper 20 bits, sign extended
            end else if (word == rv_pkg::INSTR_LOAD_KEY) begin
                ref_x5 = ref_key;
            end else if (word == rv_pkg::INSTR_STORE_ART) begin
                found = 1'b1;
            end else if (ref_in_trap && word == rv_pkg::INSTR_MRET) begin
                ref_in_trap = 1'b0;    // Back to the saved main word
                ref_idx     = ref_ret;
            end
        end
        return ref_x5;
    endfunction

    task automatic report_value(input string name, input logic [63:0] got,
                                input logic [63:0] want);
        $display("[ERROR] %0d ns %s got %h expected %h", $time, name, got, want);
        errors++;
    endtask

    task automatic report_fault(input string what);
        $display("Failure at %0d ns: %s", $time, what);
        errors++;
    endtask

    // Compare every art write and watch heartbeat and acknowledge
    always @(negedge clk) begin
        if (in_run && heartbeat == prev_hb) begin
            report_value("heartbeat", 64'(heartbeat), 64'(!prev_hb));
        end
        prev_hb = heartbeat;
        if (interrupt_ack) begin
            ack_count++;
        end
        if (art_strobe) begin
            exp_art = predict_art();
            if (art_data !== exp_art) begin
                report_value("art_data", art_data, exp_art);
            end
            art_count++;
            last_store_idx = ref_idx - 4'd1;
            last_in_trap   = ref_in_trap;
        end
    end

    task automatic wait_for_art(input int target, input int limit);
        int cycles;
        cycles = 0;
        while (art_count < target && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (art_count < target) begin
            report_fault("timed out waiting for art writes");
        end
    endtask

    // Polled on rising edges, so the strobe of that store is seen one cycle late
    task automatic wait_for_store(input logic [3:0] idx, input int limit);
        int   cycles;
        int   start;
        logic hit;
        cycles = 0;
        start  = art_count;
        hit    = 1'b0;
        while (!hit && cycles < limit) begin
            @(posedge clk);
            cycles++;
            hit = (art_count != start) && !last_in_trap && (last_store_idx == idx);
        end
        if (!hit) begin
            report_fault("timed out waiting for a given main program store");
        end
    endtask

    task automatic interrupt_event(input logic [3:0] after_store);
        int cycles;
        int acks_before;
        wait_for_store(after_store, 200);
        @(negedge clk);
        key_data         = new_key();  // New key per interrupt event
        ref_key          = key_data;
        trap_idx         = after_store + 4'd4; // Word in ir at the trap edge still retires
        trap_armed       = 1'b1;
        acks_before      = ack_count;
        interrupt_vector = 4'd1;
        @(negedge clk);
        if (interrupt_ack !== 1'b1) begin
            report_value("interrupt_ack", 64'(interrupt_ack), 64'd1);
        end
        if (pc !== rv_pkg::TRAP_VECTOR) begin
            report_value("pc", pc, rv_pkg::TRAP_VECTOR);
        end
        @(negedge clk);                // Request still held while pending
        if (interrupt_ack !== 1'b0) begin
            report_value("interrupt_ack", 64'(interrupt_ack), 64'd0);
        end
        if (interrupt_pending !== 1'b1) begin
            report_value("interrupt_pending", 64'(interrupt_pending), 64'd1);
        end
        interrupt_vector = 4'd0;
        cycles = 0;
        while (interrupt_pending && cycles < 50) begin
            @(negedge clk);
            cycles++;
        end
        if (interrupt_pending) begin
            report_fault("interrupt_pending did not fall after the handler returned");
        end
        if (ack_count - acks_before != 1) begin
            report_fault("interrupt event did not give exactly one acknowledge pulse");
        end
    endtask

    initial begin
        reset            = 1'b0;
        interrupt_vector = 4'd0;
        key_data         = new_key();
        ref_key          = key_data;
        repeat (4) begin
            @(negedge clk);
            if (pc !== rv_pkg::RAM_BASE) begin
                report_value("pc", pc, rv_pkg::RAM_BASE);
            end
            if (interrupt_ack !== 1'b0 || interrupt_pending !== 1'b0) begin
                report_fault("interrupt outputs not low in reset");
            end
            if (art_strobe !== 1'b0 || heartbeat !== 1'b0) begin
                report_fault("art_strobe or heartbeat not low in reset");
            end
        end
        reset = 1'b1;
        @(negedge clk);
        in_run = 1'b1;
        wait_for_art(8, 200);          // More than a full loop of LUI and key writes
        interrupt_event(4'd3);
        interrupt_event(4'd9);
        interrupt_event(4'd14);
        wait_for_art(art_count + 12, 400);
        $display("Art writes %0d, interrupt acks %0d, errors %0d", art_count, ack_count, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
src/rv_pkg.sv
src/inst_rom.sv
src/rv_decode.sv
src/rv_trap.sv
src/rv_execute.sv
src/periph_bus.sv
src/soc_top.sv
verification/soc_assert.sv
verification/soc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the SoC testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sources.f --top-module soc_tb \
        -Mdir obj_dir -o soc_sim; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/soc_sim)
sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "Result: PASSED"; then
    exit 0
fi

echo "Pass line not found in simulation output"
exit 1
